// ==== sources.f ====
source/CachePkg.sv
source/MemBusPkg.sv
source/CacheControl.sv
source/CacheArray.sv
source/LineFillBuffer.sv
source/LineWriteBuffer.sv
source/DataCacheTop.sv
tests/MemoryModel.sv
tests/DataCacheTb.sv

// ==== Bender.yml ====
package:
  name: data_cache

sources:
  - source/CachePkg.sv
  - source/MemBusPkg.sv
  - source/CacheControl.sv
  - source/CacheArray.sv
  - source/LineFillBuffer.sv
  - source/LineWriteBuffer.sv
  - source/DataCacheTop.sv
  - target: test
    files:
      - tests/MemoryModel.sv
      - tests/DataCacheTb.sv

// ==== tests/DataCacheTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module DataCacheTb
    import CachePkg::*;
    import MemBusPkg::*;
();

    localparam int          NumLines     = 128;
    localparam int          WordsPerLine = 8;
    localparam int          MemWords     = 16384;
    localparam int          AddrBits     = $clog2(MemWords);
    localparam tWord        Pattern      = 32'h3C5A_96E1;
    localparam int unsigned Seed         = 35064;
    localparam int          Limit        = 400;

    logic    Clk = 1'b0;
    logic    rst;
    tCpuReq  CpuReq;
    tFillRsp FillRsp;
    logic    WbReady;
    tWord    RdData;
    logic    Stall;
    tFillReq FillReq;
    tWbBeat  WbBeat;
    logic    FillActive;

    // Memory contents as the CPU should see them
    tWord Image [MemWords];

    int          errors;
    int          tests;
    int          errorsAtStart;
    int          fillCount;
    tAddr        lastFillAddr;
    logic [2:0]  lastCrt;
    tAddr        beatAddr [$];
    tWord        beatData [$];
    logic [31:0] rng;
    logic        prevReq;
    logic        prevValid;
    logic        prevReady;
    tWbBeat      prevBeat;

    always #10 Clk = ~Clk;

    DataCacheTop #(
        .NumLines     (NumLines),
        .WordsPerLine (WordsPerLine)
    ) DUT (
        .Clk     (Clk),
        .rst     (rst),
        .CpuReq  (CpuReq),
        .FillRsp (FillRsp),
        .WbReady (WbReady),
        .RdData  (RdData),
        .Stall   (Stall),
        .FillReq (FillReq),
        .WbBeat  (WbBeat)
    );

    MemoryModel #(
        .WordsPerLine (WordsPerLine),
        .MemWords     (MemWords),
        .Pattern      (Pattern),
        .Seed         (Seed)
    ) Memory (
        .Clk        (Clk),
        .rst        (rst),
        .FillReq    (FillReq),
        .WbBeat     (WbBeat),
        .FillRsp    (FillRsp),
        .WbReady    (WbReady),
        .FillActive (FillActive)
    );

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int wordIndex(input tAddr addr);
        return int'(addr[AddrBits+1:2]);
    endfunction

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic expectWord(input string what, input tWord got, input tWord exp);
        assert (got === exp)
            else reportMismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $finish;
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("Test %0d %s done, %0d errors", tests, name, errors - errorsAtStart);
        errorsAtStart = errors;
    endtask

    // One CPU access, held until Stall drops
    task automatic access(input logic write, input tAddr addr, input tWord wrData,
                          output tWord rdData, output int waits);
        @(negedge Clk);
        CpuReq.En     = 1'b1;
        CpuReq.Rw     = write;
        CpuReq.Addr   = addr;
        CpuReq.WrData = wrData;
        waits = 0;
        @(posedge Clk);
        while (Stall) begin
            waits++;
            if (waits > Limit) begin
                abortRun($sformatf("Timeout: access to %h still stalled", addr));
            end
            @(posedge Clk);
        end
        rdData = RdData;
        if (write) begin
            Image[wordIndex(addr)] = wrData;
        end
        @(negedge Clk);
        CpuReq.En = 1'b0;
    endtask

    task automatic readCheck(input tAddr addr);
        tWord got;
        int   waits;
        access(1'b0, addr, '0, got, waits);
        expectWord($sformatf("read %h", addr), got, Image[wordIndex(addr)]);
    endtask

    // Let fill and writeback traffic drain, then the line write
    task automatic waitQuiet();
        int n;
        n = 0;
        @(negedge Clk);
        while (FillActive || WbBeat.Valid) begin
            n++;
            if (n > Limit) begin
                abortRun("Timeout: memory traffic never went idle");
            end
            @(negedge Clk);
        end
        repeat (2) @(negedge Clk);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Bus monitor and protocol checks
    ////////////////////////////////////////////////////////////////////

    always @(posedge Clk) begin
        if (rst) begin
            prevReq   = 1'b0;
            prevValid = 1'b0;
            prevReady = 1'b0;
        end else begin
            assert (!(prevReq && FillReq.Req))
                else reportMismatch("FillReq.Req high for more than one cycle");
            // Beat must hold while memory pushes back
            assert (!(prevValid && !prevReady) || (WbBeat === prevBeat))
                else reportMismatch("writeback beat changed while WbReady low");
            if (FillReq.Req) begin
                fillCount++;
                lastFillAddr = FillReq.LineAddr;
                lastCrt      = FillReq.CrtOffset;
            end
            if (WbBeat.Valid && WbReady) begin
                beatAddr.push_back(WbBeat.Addr);
                beatData.push_back(WbBeat.Data);
            end
            prevReq   = FillReq.Req;
            prevValid = WbBeat.Valid;
            prevReady = WbReady;
            prevBeat  = WbBeat;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        tWord got;
        int   waits;
        int   fills;
        logic write;
        tAddr addr;
        tWord data;
        int   n;

        errors        = 0;
        tests         = 0;
        errorsAtStart = 0;
        fillCount     = 0;
        rng           = Seed;
        CpuReq        = '0;
        rst           = 1'b1;
        for (int i = 0; i < MemWords; i++) begin
            Image[i] = tWord'(i) ^ Pattern;
        end
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        @(posedge Clk);
        assert (!Stall && !FillReq.Req && !WbBeat.Valid)
            else reportMismatch("outputs not idle after reset");

        // Cold read miss, critical word first
        fills = fillCount;
        addr  = 32'h0000_1234;
        access(1'b0, addr, '0, got, waits);
        expectWord("read miss 00001234", got, Image[wordIndex(addr)]);
        assert (waits > 0) else reportMismatch("read miss did not stall");
        waitQuiet();
        assert (fillCount == fills + 1)
            else reportMismatch($sformatf("%0d fill requests", fillCount - fills));
        assert (lastFillAddr == (addr & ~32'h1F) && lastCrt == addr[4:2])
            else reportMismatch($sformatf("fill %h offset %0d", lastFillAddr, lastCrt));
        finishTest("read miss clean line");

        // Same line, other word
        fills = fillCount;
        addr  = 32'h0000_1228;
        access(1'b0, addr, '0, got, waits);
        expectWord("read hit 00001228", got, Image[wordIndex(addr)]);
        assert (waits == 0) else reportMismatch("read hit stalled");
        repeat (2) @(negedge Clk);
        assert (fillCount == fills) else reportMismatch("read hit sent a fill request");
        finishTest("read hit after fill");

        access(1'b1, 32'h0000_1238, 32'hCAFE_0001, got, waits);
        assert (waits == 0) else reportMismatch("write hit stalled");
        readCheck(32'h0000_1238);
        readCheck(32'h0000_1234);
        readCheck(32'h0000_123C);
        finishTest("write hit then read");

        // Index 2 still invalid, allocate and merge
        access(1'b1, 32'h0000_2044, 32'hBEEF_0004, got, waits);
        assert (waits > 0) else reportMismatch("write miss did not stall");
        for (int w = 0; w < WordsPerLine; w++) begin
            readCheck(tAddr'(32'h0000_2040 + 4 * w));
        end
        finishTest("write miss with allocate");

        // Tag 3 conflicts with the dirty line at 00001220
        beatAddr.delete();
        beatData.delete();
        access(1'b0, 32'h0000_3230, '0, got, waits);
        expectWord("read miss 00003230", got, Image[wordIndex(32'h0000_3230)]);
        n = 0;
        while (beatAddr.size() < WordsPerLine) begin
            n++;
            if (n > Limit) begin
                abortRun("Timeout: dirty victim writeback never finished");
            end
            @(negedge Clk);
        end
        waitQuiet();
        assert (beatAddr.size() == WordsPerLine)
            else reportMismatch($sformatf("%0d writeback beats", beatAddr.size()));
        for (int i = 0; i < beatAddr.size(); i++) begin
            assert (beatAddr[i] == tAddr'(32'h0000_1220 + 4 * i))
                else reportMismatch($sformatf("beat %0d address %h", i, beatAddr[i]));
            expectWord($sformatf("writeback beat %0d", i), beatData[i],
                       Image[wordIndex(beatAddr[i])]);
        end
        // Evicted line comes back from memory with the stored word
        readCheck(32'h0000_1238);
        waitQuiet();
        assert (beatAddr.size() == WordsPerLine)
            else reportMismatch("clean eviction wrote back");
        finishTest("dirty eviction with back-pressure");

        // Four tags over two indexes
        for (int i = 0; i < 200; i++) begin
            rng   = xorshift(rng);
            write = rng[8];
            addr  = {18'd0, rng[1:0], 7'h11 + 7'(rng[2]), rng[5:3], 2'b00};
            rng   = xorshift(rng);
            data  = rng;
            access(write, addr, data, got, waits);
            if (!write) begin
                expectWord($sformatf("random read %h", addr), got, Image[wordIndex(addr)]);
            end
        end
        waitQuiet();
        finishTest("random mix");

        $display("Summary: %0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/MemoryModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module MemoryModel import CachePkg::*; import MemBusPkg::*; #(
    parameter int          WordsPerLine = 8,
    parameter int          MemWords     = 16384,
    parameter tWord        Pattern      = 32'h3C5A_96E1,
    parameter int unsigned Seed         = 35064
) (
    input  wire          Clk,
    input  wire          rst,
    input  wire tFillReq FillReq,
    input  wire tWbBeat  WbBeat,
    output tFillRsp      FillRsp,
    output logic         WbReady,
    output logic         FillActive
);

    localparam int AddrBits = $clog2(MemWords);

    // Backing store, word addressed
    tWord        Mem [MemWords];
    logic [31:0] RandState;
    tAddr        LineBase;
    int          CrtOff;
    int          Sent;
    int          Pending;
    int          WordIdx;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Words of the current line still owed
    assign FillActive = (Pending != 0);

    initial begin
        for (int i = 0; i < MemWords; i++) begin
            Mem[i] = tWord'(i) ^ Pattern;
        end
        RandState = Seed;
        LineBase  = '0;
        CrtOff    = 0;
        Sent      = 0;
        Pending   = 0;
        FillRsp   = '0;
        WbReady   = 1'b0;
    end

    // Writeback beats land at the rising edge
    always @(posedge Clk) begin
        if (!rst && WbBeat.Valid && WbReady) begin
            Mem[WbBeat.Addr[AddrBits+1:2]] <= WbBeat.Data;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Fill responses and back-pressure, falling edge
    ////////////////////////////////////////////////////////////////////

    always @(negedge Clk) begin
        RandState = xorshift(RandState);
        if (rst) begin
            Pending <= 0;
            FillRsp <= '0;
            WbReady <= 1'b0;
        end else begin
            WbReady <= RandState[7];
            if (FillReq.Req) begin
                // Request pulse is a registered level, stable all cycle
                LineBase <= FillReq.LineAddr;
                CrtOff   <= int'(FillReq.CrtOffset);
                Sent     <= 0;
                Pending  <= WordsPerLine;
                FillRsp  <= '0;
            end else if (Pending != 0 && RandState[1:0] != 2'b00) begin
                // Wrap from the critical word
                WordIdx = int'(LineBase[AddrBits+1:2]) + ((CrtOff + Sent) % WordsPerLine);
                FillRsp.Valid <= 1'b1;
                FillRsp.Data  <= Mem[WordIdx];
                Sent          <= Sent + 1;
                Pending       <= Pending - 1;
            end else begin
                // Gap, about one cycle in four
                FillRsp <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/DataCacheTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module DataCacheTop import CachePkg::*; import MemBusPkg::*; #(
    parameter int NumLines     = 128,
    parameter int WordsPerLine = 8
) (
    input  wire          Clk,
    input  wire          rst,
    input  wire tCpuReq  CpuReq,
    input  wire tFillRsp FillRsp,
    input  wire          WbReady,
    output tWord         RdData,
    output logic         Stall,
    output tFillReq      FillReq,
    output tWbBeat       WbBeat
);

    // Controller to array
    tCacheCmd CacheCmd;
    logic     Hit;
    logic     VictimDirty;
    tWord     ArrayWord;
    tWord     VictimLine [WordsPerLine];
    tAddr     VictimAddr;

    // Buffers
    tWord     FillLine [WordsPerLine];
    tAddr     FillAddr;
    tWord     CrtWord;
    logic     FillStart;
    logic     FillFirstWord;
    logic     FillCompleted;
    logic     FillBusy;
    logic     WbStart;
    logic     WbCompleted;
    logic     ServeFill;

    // Critical word bypass on a read miss
    assign RdData = ServeFill ? CrtWord : ArrayWord;

    CacheControl #(
        .NumLines     (NumLines),
        .WordsPerLine (WordsPerLine)
    ) Control (
        .Clk           (Clk),
        .rst           (rst),
        .CpuReq        (CpuReq),
        .Hit           (Hit),
        .VictimDirty   (VictimDirty),
        .FillFirstWord (FillFirstWord),
        .FillCompleted (FillCompleted),
        .FillBusy      (FillBusy),
        .WbCompleted   (WbCompleted),
        .Stall         (Stall),
        .CacheCmd      (CacheCmd),
        .FillStart     (FillStart),
        .WbStart       (WbStart),
        .ServeFill     (ServeFill)
    );

    CacheArray #(
        .NumLines     (NumLines),
        .WordsPerLine (WordsPerLine)
    ) Array (
        .Clk         (Clk),
        .rst         (rst),
        .Addr        (CpuReq.Addr),
        .WrData      (CpuReq.WrData),
        .CacheCmd    (CacheCmd),
        .FillLine    (FillLine),
        .FillAddr    (FillAddr),
        .RdWord      (ArrayWord),
        .Hit         (Hit),
        .VictimDirty (VictimDirty),
        .VictimLine  (VictimLine),
        .VictimAddr  (VictimAddr)
    );

    LineFillBuffer #(
        .WordsPerLine (WordsPerLine)
    ) FillBuf (
        .Clk           (Clk),
        .rst           (rst),
        .FillStart     (FillStart),
        .Addr          (CpuReq.Addr),
        .FillRsp       (FillRsp),
        .FillReq       (FillReq),
        .FillLine      (FillLine),
        .FillAddr      (FillAddr),
        .CrtWord       (CrtWord),
        .FillFirstWord (FillFirstWord),
        .FillCompleted (FillCompleted),
        .FillBusy      (FillBusy)
    );

    LineWriteBuffer #(
        .WordsPerLine (WordsPerLine)
    ) WriteBuf (
        .Clk         (Clk),
        .rst         (rst),
        .WbStart     (WbStart),
        .VictimLine  (VictimLine),
        .VictimAddr  (VictimAddr),
        .WbReady     (WbReady),
        .WbBeat      (WbBeat),
        .WbCompleted (WbCompleted)
    );

endmodule

`default_nettype wire

// ==== source/LineWriteBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module LineWriteBuffer import CachePkg::*; import MemBusPkg::*; #(
    parameter int WordsPerLine = 8
) (
    input  wire       Clk,
    input  wire       rst,
    input  wire       WbStart,
    input  wire tWord VictimLine [WordsPerLine],
    input  wire tAddr VictimAddr,
    input  wire       WbReady,
    output tWbBeat    WbBeat,
    output logic      WbCompleted
);

    localparam int OffBits = $clog2(WordsPerLine);
    localparam int IdxLo   = OffBits + 2;

    logic               Active;
    logic               Fire;
    logic [OffBits-1:0] TxCount;
    tAddr               LineBase;
    tWord               Words [WordsPerLine];

    // Beat accepted
    assign Fire        = Active && WbReady;
    assign WbCompleted = Fire && (TxCount == OffBits'(WordsPerLine - 1));

    // Ascending word order
    always_comb begin
        WbBeat.Valid = Active;
        WbBeat.Addr  = {LineBase[31:IdxLo], TxCount, 2'b00};
        WbBeat.Data  = Words[TxCount];
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            Active  <= 1'b0;
            TxCount <= '0;
        end else if (WbStart) begin
            Active  <= 1'b1;
            TxCount <= '0;
        end else if (Fire) begin
            TxCount <= TxCount + 1'b1;
            if (WbCompleted) begin
                Active <= 1'b0;
            end
        end
    end

    // Snapshot of the victim, array may be refilled later
    always_ff @(posedge Clk) begin
        if (WbStart) begin
            Words    <= VictimLine;
            LineBase <= VictimAddr;
        end
    end

endmodule

`default_nettype wire

// ==== source/LineFillBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module LineFillBuffer import CachePkg::*; import MemBusPkg::*; #(
    parameter int WordsPerLine = 8
) (
    input  wire          Clk,
    input  wire          rst,
    input  wire          FillStart,
    input  wire tAddr    Addr,
    input  wire tFillRsp FillRsp,
    output tFillReq      FillReq,
    output tWord         FillLine [WordsPerLine],
    output tAddr         FillAddr,
    output tWord         CrtWord,
    output logic         FillFirstWord,
    output logic         FillCompleted,
    output logic         FillBusy
);

    localparam int OffBits = $clog2(WordsPerLine);
    localparam int IdxLo   = OffBits + 2;

    logic               Busy;
    logic               ReqPulse;
    logic               Accept;
    logic [OffBits-1:0] CrtOff;
    logic [OffBits-1:0] RxCount;
    logic [OffBits-1:0] WrOff;
    tAddr               LineBase;
    tWord               Words [WordsPerLine];

    assign Accept = Busy && FillRsp.Valid;

    // Wrap order, starting at the critical word
    assign WrOff = CrtOff + RxCount;

    assign FillFirstWord = Accept && (RxCount == '0);
    assign FillCompleted = Accept && (RxCount == OffBits'(WordsPerLine - 1));
    assign FillBusy      = Busy;
    // Critical word bypass
    assign CrtWord       = FillRsp.Data;
    assign FillAddr      = LineBase;
    assign FillLine      = Words;

    always_comb begin
        FillReq.Req       = ReqPulse;
        FillReq.LineAddr  = LineBase;
        FillReq.CrtOffset = 3'(CrtOff);
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            Busy     <= 1'b0;
            ReqPulse <= 1'b0;
            RxCount  <= '0;
        end else begin
            // Request goes out the cycle after the miss
            ReqPulse <= FillStart;
            if (FillStart) begin
                Busy    <= 1'b1;
                RxCount <= '0;
            end else if (Accept) begin
                RxCount <= RxCount + 1'b1;
                if (FillCompleted) begin
                    Busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (FillStart) begin
            LineBase <= {Addr[31:IdxLo], {IdxLo{1'b0}}};
            CrtOff   <= Addr[IdxLo-1:2];
        end
        if (Accept) begin
            Words[WrOff] <= FillRsp.Data;
        end
    end

endmodule

`default_nettype wire

// ==== source/CacheArray.sv ====
`timescale 1ns/1ns
`default_nettype none

module CacheArray import CachePkg::*; #(
    parameter int NumLines     = 128,
    parameter int WordsPerLine = 8
) (
    input  wire           Clk,
    input  wire           rst,
    input  wire tAddr     Addr,
    input  wire tWord     WrData,
    input  wire tCacheCmd CacheCmd,
    input  wire tWord     FillLine [WordsPerLine],
    input  wire tAddr     FillAddr,
    output tWord          RdWord,
    output logic          Hit,
    output logic          VictimDirty,
    output tWord          VictimLine [WordsPerLine],
    output tAddr          VictimAddr
);

    // Address split: tag | index | word offset | byte
    localparam int OffBits = $clog2(WordsPerLine);
    localparam int IdxBits = $clog2(NumLines);
    localparam int IdxLo   = OffBits + 2;
    localparam int TagLo   = IdxLo + IdxBits;

    logic [31:TagLo]     Tags [NumLines];
    logic [NumLines-1:0] Valid;
    logic [NumLines-1:0] Dirty;
    tWord                Data [NumLines][WordsPerLine];

    logic [IdxBits-1:0]  ReqIdx;
    logic [IdxBits-1:0]  FillIdx;
    logic [OffBits-1:0]  ReqOff;
    logic [31:TagLo]     ReqTag;
    logic [31:TagLo]     FillTag;

    assign ReqIdx  = Addr[TagLo-1:IdxLo];
    assign ReqOff  = Addr[IdxLo-1:2];
    assign ReqTag  = Addr[31:TagLo];
    assign FillIdx = FillAddr[TagLo-1:IdxLo];
    assign FillTag = FillAddr[31:TagLo];

    // Lookup
    assign Hit         = Valid[ReqIdx] && (Tags[ReqIdx] == ReqTag);
    assign VictimDirty = Valid[ReqIdx] && Dirty[ReqIdx];
    assign RdWord      = Data[ReqIdx][ReqOff];

    // Victim rebuilt from the stored tag
    assign VictimAddr = {Tags[ReqIdx], ReqIdx, {IdxLo{1'b0}}};

    always_comb begin
        for (int w = 0; w < WordsPerLine; w++) begin
            VictimLine[w] = Data[ReqIdx][w];
        end
    end

    // Line state
    always_ff @(posedge Clk) begin
        if (rst) begin
            Valid <= '0;
            Dirty <= '0;
        end else begin
            if (CacheCmd.WordWrite) begin
                Dirty[ReqIdx] <= 1'b1;
            end
            // Clean refill, dirty if a store was merged in
            if (CacheCmd.LineWrite) begin
                Valid[FillIdx] <= 1'b1;
                Dirty[FillIdx] <= CacheCmd.Merge;
            end
        end
    end

    // Tags and data
    always_ff @(posedge Clk) begin
        if (CacheCmd.WordWrite) begin
            Data[ReqIdx][ReqOff] <= WrData;
        end
        if (CacheCmd.LineWrite) begin
            Tags[FillIdx] <= FillTag;
            for (int w = 0; w < WordsPerLine; w++) begin
                if (CacheCmd.Merge && (ReqOff == OffBits'(w))) begin
                    Data[FillIdx][w] <= CacheCmd.MergeData;
                end else begin
                    Data[FillIdx][w] <= FillLine[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/CacheControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module CacheControl import CachePkg::*; #(
    parameter int NumLines     = 128,
    parameter int WordsPerLine = 8
) (
    input  wire         Clk,
    input  wire         rst,
    input  wire tCpuReq CpuReq,
    input  wire         Hit,
    input  wire         VictimDirty,
    input  wire         FillFirstWord,
    input  wire         FillCompleted,
    input  wire         FillBusy,
    input  wire         WbCompleted,
    output logic        Stall,
    output tCacheCmd    CacheCmd,
    output logic        FillStart,
    output logic        WbStart,
    output logic        ServeFill
);

    // Line index field of the byte address
    localparam int IdxLo = $clog2(WordsPerLine) + 2;
    localparam int IdxHi = IdxLo + $clog2(NumLines) - 1;

    tReadState  ReadState;
    tWriteState WriteState;

    logic               FillPending;
    logic [IdxHi:IdxLo] FillIdx;
    logic               FillSeen;
    logic               WbSeen;
    logic               SameLine;
    logic               StartMiss;
    logic               FillOk;
    logic               WbOk;
    logic               CrtWait;

    // Request targets the line currently being refilled
    assign SameLine = FillPending && (CpuReq.Addr[IdxHi:IdxLo] == FillIdx);

    // One miss in flight at a time
    assign StartMiss = CpuReq.En && !Hit && !FillPending && !FillBusy && (WriteState == WrIdle);

    // Completion seen now or in an earlier cycle
    assign FillOk = FillSeen || FillCompleted;
    assign WbOk   = WbSeen || WbCompleted;

    assign CrtWait   = (ReadState == RdMissDirty) || (ReadState == RdMissClean);
    assign FillStart = StartMiss;
    assign WbStart   = StartMiss && VictimDirty;
    assign ServeFill = CrtWait && FillFirstWord;

    // Stall generation
    always_comb begin
        if (CrtWait) begin
            // Released by the critical word
            Stall = !FillFirstWord;
        end else if (WriteState != WrIdle) begin
            Stall = 1'b1;
        end else begin
            // Any miss, or any access to the filling line
            Stall = CpuReq.En && (SameLine || !Hit);
        end
    end

    // Array commands
    always_comb begin
        CacheCmd.WordWrite = CpuReq.En && CpuReq.Rw && Hit && !Stall;
        CacheCmd.LineWrite = (ReadState == RdWriteLine) || (WriteState == WrMergeLine);
        CacheCmd.Merge     = (WriteState == WrMergeLine);
        CacheCmd.MergeData = CpuReq.WrData;
    end

    //////////////////////////////////////////////////////////////////////
    // Fill bookkeeping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            FillPending <= 1'b0;
            FillSeen    <= 1'b0;
            WbSeen      <= 1'b0;
        end else if (StartMiss) begin
            FillPending <= 1'b1;
            FillSeen    <= 1'b0;
            WbSeen      <= 1'b0;
        end else begin
            // Pending until the line lands in the array
            if (CacheCmd.LineWrite) begin
                FillPending <= 1'b0;
            end
            if (FillCompleted) begin
                FillSeen <= 1'b1;
            end
            if (WbCompleted) begin
                WbSeen <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (StartMiss) begin
            FillIdx <= CpuReq.Addr[IdxHi:IdxLo];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read miss FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            ReadState <= RdIdle;
        end else begin
            case (ReadState)
                RdIdle: begin
                    if (StartMiss && !CpuReq.Rw) begin
                        ReadState <= VictimDirty ? RdMissDirty : RdMissClean;
                    end
                end
                RdMissDirty: begin
                    if (FillFirstWord) begin
                        ReadState <= RdWaitDirty;
                    end
                end
                RdMissClean: begin
                    if (FillFirstWord) begin
                        ReadState <= RdWaitClean;
                    end
                end
                // CPU runs on, rest of line and victim still moving
                RdWaitDirty: begin
                    if (FillOk && WbOk) begin
                        ReadState <= RdWriteLine;
                    end
                end
                RdWaitClean: begin
                    if (FillOk) begin
                        ReadState <= RdWriteLine;
                    end
                end
                RdWriteLine: ReadState <= RdIdle;
                default:     ReadState <= RdIdle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write miss FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            WriteState <= WrIdle;
        end else begin
            case (WriteState)
                WrIdle: begin
                    if (StartMiss && CpuReq.Rw) begin
                        WriteState <= VictimDirty ? WrFillRw : WrFillR;
                    end else if (CpuReq.En && CpuReq.Rw && SameLine) begin
                        // Store into the line a read miss is refilling
                        WriteState <= WrWriteWait;
                    end
                end
                WrFillRw: begin
                    if (FillOk && WbOk) begin
                        WriteState <= WrMergeLine;
                    end
                end
                WrFillR: begin
                    if (FillOk) begin
                        WriteState <= WrMergeLine;
                    end
                end
                // Store then hits and completes the cycle after
                WrMergeLine: WriteState <= WrIdle;
                WrWriteWait: begin
                    if (!FillPending) begin
                        WriteState <= WrIdle;
                    end
                end
                default: WriteState <= WrIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/MemBusPkg.sv ====
`default_nettype none

package MemBusPkg;

    import CachePkg::*;

    // Line request towards memory, Req is a single cycle pulse
    typedef struct packed {
        logic       Req;
        tAddr       LineAddr;   // offset bits zero
        logic [2:0] CrtOffset;  // word the CPU is waiting for
    } tFillReq;

    // One returned word per Valid strobe, wrapping from CrtOffset
    typedef struct packed {
        logic Valid;
        tWord Data;
    } tFillRsp;

    // Writeback beat, Valid held until WbReady
    typedef struct packed {
        logic Valid;
        tAddr Addr;
        tWord Data;
    } tWbBeat;

endpackage

`default_nettype wire

// ==== source/CachePkg.sv ====
`default_nettype none

package CachePkg;

    // Data word and byte address
    typedef logic [31:0] tWord;
    typedef logic [31:0] tAddr;

    // Processor request, held stable by the CPU while Stall is high
    typedef struct packed {
        logic En;
        logic Rw;       // 1 = store
        tAddr Addr;
        tWord WrData;
    } tCpuReq;

    // Array control from the miss controller
    typedef struct packed {
        logic WordWrite;    // single word store on a hit
        logic LineWrite;    // whole line from the fill buffer
        logic Merge;        // overlay the store word on the filled line
        tWord MergeData;
    } tCacheCmd;

    // Read miss FSM
    typedef enum logic [2:0] {
        RdIdle,
        RdMissDirty,
        RdMissClean,
        RdWaitDirty,
        RdWaitClean,
        RdWriteLine
    } tReadState;

    // Write miss FSM
    typedef enum logic [2:0] {
        WrIdle,
        WrFillRw,
        WrFillR,
        WrMergeLine,
        WrWriteWait
    } tWriteState;

endpackage

`default_nettype wire
